/* common/amp_pkg.sv */
package amp_pkg;

	// Seven bits cover 0..127 for every panel level
	typedef logic [6:0] level_t;

	// PS/2 set 2 make codes
	localparam logic [7:0] SC_ESC       = 8'h76; // Soft reset
	localparam logic [7:0] SC_BREAK     = 8'hF0; // Release prefix
	localparam logic [7:0] SC_FX1       = 8'h16;
	localparam logic [7:0] SC_FX2       = 8'h1E;
	localparam logic [7:0] SC_FX3       = 8'h26;
	localparam logic [7:0] SC_FX4       = 8'h25;
	localparam logic [7:0] SC_FX5       = 8'h2E;
	localparam logic [7:0] SC_FX6       = 8'h36;
	localparam logic [7:0] SC_FX7       = 8'h3D;
	localparam logic [7:0] SC_FX8       = 8'h3E;
	localparam logic [7:0] SC_CLEAR_FX  = 8'h21; // All effects off
	localparam logic [7:0] SC_GAIN_UP   = 8'h1D;
	localparam logic [7:0] SC_GAIN_DN   = 8'h15;
	localparam logic [7:0] SC_TREBLE_UP = 8'h1B;
	localparam logic [7:0] SC_TREBLE_DN = 8'h1C;
	localparam logic [7:0] SC_BASS_UP   = 8'h22;
	localparam logic [7:0] SC_BASS_DN   = 8'h1A;
	localparam logic [7:0] SC_REC_ON    = 8'h4A;
	localparam logic [7:0] SC_REC_OFF   = 8'h49;
	localparam logic [7:0] SC_PLAY_ON   = 8'h52;
	localparam logic [7:0] SC_PLAY_OFF  = 8'h4C;

	// Panel commands, one per decoded key press
	typedef enum logic [3:0] {
		CMD_NONE,
		CMD_SOFT_RESET,
		CMD_FX_TOGGLE,
		CMD_FX_CLEAR,
		CMD_GAIN_UP,
		CMD_GAIN_DN,
		CMD_TREBLE_UP,
		CMD_TREBLE_DN,
		CMD_BASS_UP,
		CMD_BASS_DN,
		CMD_REC_ON,
		CMD_REC_OFF,
		CMD_PLAY_ON,
		CMD_PLAY_OFF
	} amp_cmd_e;

	typedef struct packed {
		amp_cmd_e    op;
		logic [2:0]  fx_idx; // Effect number minus one, toggle only
	} key_cmd_t;

	typedef struct packed {
		level_t      gain;
		level_t      treble;
		level_t      bass;
		logic [7:0]  effects; // Bit 0 is effect 1
		logic        record;
		logic        play;
	} amp_state_t;

	// Defaults handed down by the top level
	localparam level_t DEF_MAX_LEVEL = 7'd100;
	localparam level_t DEF_RESET_LEVEL = 7'd50;
	// Full-scale input over this lands near 127
	localparam logic signed [31:0] DEF_AMP_DIVISOR = 32'd16_909_320;

endpackage

/* hw/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder import amp_pkg::*; (
	input  logic        CLOCK_50,
	input  logic        rst,
	input  logic [7:0]  scan_code,
	input  logic        scan_valid,
	output key_cmd_t    cmd
);

	logic [7:0] code_q;   // Byte captured on the strobe
	logic       valid_q;  // Strobe delayed along with it
	logic       brk_flag; // Last byte was F0
	key_cmd_t   dec;      // Combinational lookup of code_q

	// Capture stage, payload only
	always_ff @(posedge CLOCK_50) begin
		if (scan_valid)
			code_q <= scan_code;
	end

	// Scan code to opcode
	always_comb begin
		dec.op = CMD_NONE;
		dec.fx_idx = 3'd0;
		case (code_q)
			SC_ESC:       dec.op = CMD_SOFT_RESET;
			SC_FX1:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd0};
			SC_FX2:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd1};
			SC_FX3:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd2};
			SC_FX4:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd3};
			SC_FX5:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd4};
			SC_FX6:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd5};
			SC_FX7:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd6};
			SC_FX8:       dec = '{op: CMD_FX_TOGGLE, fx_idx: 3'd7};
			SC_CLEAR_FX:  dec.op = CMD_FX_CLEAR;
			SC_GAIN_UP:   dec.op = CMD_GAIN_UP;
			SC_GAIN_DN:   dec.op = CMD_GAIN_DN;
			SC_TREBLE_UP: dec.op = CMD_TREBLE_UP;
			SC_TREBLE_DN: dec.op = CMD_TREBLE_DN;
			SC_BASS_UP:   dec.op = CMD_BASS_UP;
			SC_BASS_DN:   dec.op = CMD_BASS_DN;
			SC_REC_ON:    dec.op = CMD_REC_ON;
			SC_REC_OFF:   dec.op = CMD_REC_OFF;
			SC_PLAY_ON:   dec.op = CMD_PLAY_ON;
			SC_PLAY_OFF:  dec.op = CMD_PLAY_OFF;
			default:      dec.op = CMD_NONE; // Unmapped key
		endcase
	end

	// Decode stage with break filtering
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			valid_q <= 1'b0;
			brk_flag <= 1'b0;
			cmd <= '{op: CMD_NONE, fx_idx: 3'd0};
		end else begin
			valid_q <= scan_valid;
			cmd <= '{op: CMD_NONE, fx_idx: 3'd0}; // One-cycle pulse
			if (valid_q) begin
				if (brk_flag)
					brk_flag <= 1'b0; // Swallow the released key
				else if (code_q == SC_BREAK)
					brk_flag <= 1'b1;
				else
					cmd <= dec;
			end
		end
	end

endmodule

/* hw/amp_settings.sv */
`timescale 1ns/1ps

module amp_settings import amp_pkg::*; #(
	parameter level_t MAX_LEVEL = DEF_MAX_LEVEL,
	parameter level_t RESET_LEVEL = DEF_RESET_LEVEL
) (
	input  logic        CLOCK_50,
	input  logic        rst,
	input  key_cmd_t    cmd,
	output amp_state_t  state
);

	// Power-up panel: knobs centred, everything else off
	localparam amp_state_t RESET_STATE = '{
		gain:    RESET_LEVEL,
		treble:  RESET_LEVEL,
		bass:    RESET_LEVEL,
		effects: 8'h00,
		record:  1'b0,
		play:    1'b0
	};

	// Saturating steps
	function automatic level_t step_up(input level_t v);
		if (v < MAX_LEVEL)
			return v + 7'd1;
		return v; // Stuck at the top
	endfunction

	function automatic level_t step_dn(input level_t v);
		if (v != 7'd0)
			return v - 7'd1;
		return v;
	endfunction

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= RESET_STATE;
		end else begin
			case (cmd.op)
				CMD_SOFT_RESET:
					state <= RESET_STATE; // Escape key
				CMD_FX_TOGGLE:
					state.effects[cmd.fx_idx] <= ~state.effects[cmd.fx_idx];
				CMD_FX_CLEAR:
					state.effects <= 8'h00;

				// Tone stack
				CMD_GAIN_UP:
					state.gain <= step_up(state.gain);
				CMD_GAIN_DN:
					state.gain <= step_dn(state.gain);
				CMD_TREBLE_UP:
					state.treble <= step_up(state.treble);
				CMD_TREBLE_DN:
					state.treble <= step_dn(state.treble);
				CMD_BASS_UP:
					state.bass <= step_up(state.bass);
				CMD_BASS_DN:
					state.bass <= step_dn(state.bass);

				// Looper latches
				CMD_REC_ON:
					state.record <= 1'b1;
				CMD_REC_OFF:
					state.record <= 1'b0;
				CMD_PLAY_ON:
					state.play <= 1'b1;
				CMD_PLAY_OFF:
					state.play <= 1'b0;

				default: ; // CMD_NONE, hold
			endcase
		end
	end

endmodule

/* hw/level_meter.sv */
`timescale 1ns/1ps

module level_meter import amp_pkg::*; #(
	parameter logic signed [31:0] AMP_DIVISOR = DEF_AMP_DIVISOR
) (
	input  logic               CLOCK_50,
	input  logic               rst,
	input  logic signed [31:0] audio_in,
	output level_t             amplitude
);

	logic signed [31:0] quotient; // Full-width, only low bits kept

	// Constant divisor, so this reduces to a multiply in synthesis
	assign quotient = audio_in / AMP_DIVISOR;

	always_ff @(posedge CLOCK_50) begin
		if (rst)
			amplitude <= 7'd1;
		else if (audio_in > 32'sd0)
			amplitude <= quotient[6:0]; // Positive half only
		else if (audio_in == 32'sd0)
			amplitude <= 7'd1; // Silence floor
		// Negative samples hold the last reading
	end

endmodule

/* hw/panel_display.sv */
`timescale 1ns/1ps

module panel_display import amp_pkg::*; (
	input  amp_state_t        state,
	output logic [5:0][6:0]   hex,
	output logic [9:0]        ledr
);

	// Active-low segments, bit 6 is g
	function automatic logic [6:0] seg7(input logic [3:0] nib);
		case (nib)
			4'h0:    return 7'b100_0000;
			4'h1:    return 7'b111_1001;
			4'h2:    return 7'b010_0100;
			4'h3:    return 7'b011_0000;
			4'h4:    return 7'b001_1001;
			4'h5:    return 7'b001_0010;
			4'h6:    return 7'b000_0010;
			4'h7:    return 7'b111_1000;
			4'h8:    return 7'b000_0000;
			4'h9:    return 7'b001_1000;
			4'hA:    return 7'b000_1000;
			4'hB:    return 7'b000_0011;
			4'hC:    return 7'b100_0110;
			4'hD:    return 7'b010_0001;
			4'hE:    return 7'b000_0110;
			default: return 7'b000_1110; // F
		endcase
	endfunction

	always_comb begin
		// Bass on the right pair
		hex[0] = seg7(state.bass[3:0]);
		hex[1] = seg7({1'b0, state.bass[6:4]});
		// Treble in the middle
		hex[2] = seg7(state.treble[3:0]);
		hex[3] = seg7({1'b0, state.treble[6:4]});
		// Gain on the left
		hex[4] = seg7(state.gain[3:0]);
		hex[5] = seg7({1'b0, state.gain[6:4]});
	end

	// Three LEDs each for record and play, middle dark
	assign ledr = {{3{state.record}}, 4'b0000, {3{state.play}}};

endmodule

/* hw/guitar_amp_top.sv */
`timescale 1ns/1ps

module guitar_amp_top import amp_pkg::*; #(
	parameter level_t MAX_LEVEL = DEF_MAX_LEVEL,
	parameter level_t RESET_LEVEL = DEF_RESET_LEVEL,
	parameter logic signed [31:0] AMP_DIVISOR = DEF_AMP_DIVISOR
) (
	input  logic               CLOCK_50,
	input  logic               rst,
	input  logic [7:0]         scan_code,  // From the PS/2 receiver
	input  logic               scan_valid,
	input  logic signed [31:0] audio_in,   // Guitar ADC sample
	output amp_state_t         state,
	output level_t             amplitude,
	output logic [5:0][6:0]    hex,        // Digit 0 in the low bits
	output logic [9:0]         ledr
);

	key_cmd_t cmd; // Single-cycle command pulse

	// Keyboard front end
	key_decoder i_key_decoder (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.cmd        (cmd)
	);

	// Knobs, effects and looper
	amp_settings #(
		.MAX_LEVEL   (MAX_LEVEL),
		.RESET_LEVEL (RESET_LEVEL)
	) i_amp_settings (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.cmd      (cmd),
		.state    (state)
	);

	level_meter #(
		.AMP_DIVISOR (AMP_DIVISOR)
	) i_level_meter (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.audio_in  (audio_in),
		.amplitude (amplitude)
	);

	// Board display
	panel_display i_panel_display (
		.state (state),
		.hex   (hex),
		.ledr  (ledr)
	);

endmodule

/* tests/amp_checker.sv */
`timescale 1ns/1ps

module amp_checker import amp_pkg::*; #(
	parameter level_t MAX_LEVEL = DEF_MAX_LEVEL,
	parameter level_t RESET_LEVEL = DEF_RESET_LEVEL,
	parameter logic signed [31:0] AMP_DIVISOR = DEF_AMP_DIVISOR
) (
	input  logic               CLOCK_50,
	input  logic               rst,
	input  logic [7:0]         scan_code,
	input  logic               scan_valid,
	input  logic signed [31:0] audio_in,
	input  amp_state_t         state,
	input  level_t             amplitude,
	input  logic [5:0][6:0]    hex,
	input  logic [9:0]         ledr,
	output int                 err_count,
	output int                 chk_count
);

	// Active low, index is the nibble
	localparam logic [6:0] SEG_TAB [0:15] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};
	localparam logic [7:0] FX_CODES [0:7] = '{
		SC_FX1, SC_FX2, SC_FX3, SC_FX4, SC_FX5, SC_FX6, SC_FX7, SC_FX8
	};

	amp_state_t         m_state;       // Model, updated on the key edge
	amp_state_t         d1;            // One edge behind
	amp_state_t         exp_state;     // Two edges behind, lines up with DUT
	logic               m_brk;         // Model break prefix seen
	level_t             m_amp;
	logic signed [31:0] quot;
	logic [5:0][6:0]    exp_hex;
	logic [9:0]         exp_ledr;
	logic               primed = 1'b0; // Set by the first reset edge
	int                 errors = 0;
	int                 checks = 0;

	assign err_count = errors;
	assign chk_count = checks;

	function automatic amp_state_t reset_state();
		amp_state_t s;
		s.gain = RESET_LEVEL;
		s.treble = RESET_LEVEL;
		s.bass = RESET_LEVEL;
		s.effects = 8'h00;
		s.record = 1'b0;
		s.play = 1'b0;
		return s;
	endfunction

	function automatic level_t lvl_up(input level_t v);
		return (v >= MAX_LEVEL) ? MAX_LEVEL : v + 7'd1; // Clamp at the top
	endfunction

	function automatic level_t lvl_dn(input level_t v);
		return (v == 7'd0) ? 7'd0 : v - 7'd1;
	endfunction

	// One received byte into the model
	task automatic apply_key(input logic [7:0] code);
		if (m_brk) begin
			m_brk = 1'b0; // Key release, no command
		end else if (code == SC_BREAK) begin
			m_brk = 1'b1;
		end else begin
			for (int i = 0; i < 8; i++)
				if (code == FX_CODES[i])
					m_state.effects[i] = ~m_state.effects[i];
			case (code)
				SC_ESC:       m_state = reset_state();
				SC_CLEAR_FX:  m_state.effects = 8'h00;
				SC_GAIN_UP:   m_state.gain = lvl_up(m_state.gain);
				SC_GAIN_DN:   m_state.gain = lvl_dn(m_state.gain);
				SC_TREBLE_UP: m_state.treble = lvl_up(m_state.treble);
				SC_TREBLE_DN: m_state.treble = lvl_dn(m_state.treble);
				SC_BASS_UP:   m_state.bass = lvl_up(m_state.bass);
				SC_BASS_DN:   m_state.bass = lvl_dn(m_state.bass);
				SC_REC_ON:    m_state.record = 1'b1;
				SC_REC_OFF:   m_state.record = 1'b0;
				SC_PLAY_ON:   m_state.play = 1'b1;
				SC_PLAY_OFF:  m_state.play = 1'b0;
				default: ; // Effect keys done above, unknown ignored
			endcase
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error: %s expected %h actual %h at %0t ns", name, exp, act, $time);
		end
	endtask

	// Model runs on the same edge that samples the inputs
	always @(posedge CLOCK_50) begin
		if (rst) begin
			m_state = reset_state();
			d1 = m_state;
			exp_state = m_state;
			m_brk = 1'b0;
			m_amp = 7'd1;
			primed = 1'b1;
		end else begin
			exp_state = d1; // Two-cycle key latency
			d1 = m_state;
			if (scan_valid)
				apply_key(scan_code);
			quot = audio_in / AMP_DIVISOR;
			if (audio_in > 32'sd0)
				m_amp = quot[6:0]; // Truncated quotient
			else if (audio_in == 32'sd0)
				m_amp = 7'd1;
			// Negative keeps the last value
		end
	end

	// Compare mid-cycle, everything settled
	always @(negedge CLOCK_50) begin
		if (primed) begin
			check_val("state.gain", exp_state.gain, state.gain);
			check_val("state.treble", exp_state.treble, state.treble);
			check_val("state.bass", exp_state.bass, state.bass);
			check_val("state.effects", exp_state.effects, state.effects);
			check_val("state.record", exp_state.record, state.record);
			check_val("state.play", exp_state.play, state.play);
			check_val("amplitude", m_amp, amplitude);
			exp_hex[0] = SEG_TAB[exp_state.bass[3:0]];
			exp_hex[1] = SEG_TAB[{1'b0, exp_state.bass[6:4]}];
			exp_hex[2] = SEG_TAB[exp_state.treble[3:0]];
			exp_hex[3] = SEG_TAB[{1'b0, exp_state.treble[6:4]}];
			exp_hex[4] = SEG_TAB[exp_state.gain[3:0]];
			exp_hex[5] = SEG_TAB[{1'b0, exp_state.gain[6:4]}];
			for (int i = 0; i < 6; i++)
				check_val($sformatf("hex[%0d]", i), exp_hex[i], hex[i]);
			exp_ledr = 10'd0; // Middle LEDs stay dark
			exp_ledr[9:7] = exp_state.record ? 3'b111 : 3'b000;
			exp_ledr[2:0] = exp_state.play ? 3'b111 : 3'b000;
			check_val("ledr", exp_ledr, ledr);
		end
	end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import amp_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int N_PHASES = 6;
	localparam int PHASE_CYCLES = 1200; // Longest phase plus drain stays below this
	localparam int MARGIN_CYCLES = 1000;
	localparam int TIMEOUT_NS =
		(RESET_CYCLES + N_PHASES * PHASE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h0aecb26e;

	// Up then down for each level, so both ends are hit
	localparam logic [7:0] LEVEL_KEYS [0:5] = '{
		SC_GAIN_UP, SC_GAIN_DN, SC_TREBLE_UP, SC_TREBLE_DN, SC_BASS_UP, SC_BASS_DN
	};
	localparam logic [7:0] FX_KEYS [0:7] = '{
		SC_FX1, SC_FX2, SC_FX3, SC_FX4, SC_FX5, SC_FX6, SC_FX7, SC_FX8
	};
	localparam logic [7:0] RP_KEYS [0:3] = '{SC_REC_ON, SC_REC_OFF, SC_PLAY_ON, SC_PLAY_OFF};
	localparam logic [7:0] ALL_KEYS [0:20] = '{
		SC_ESC, SC_FX1, SC_FX2, SC_FX3, SC_FX4, SC_FX5, SC_FX6, SC_FX7, SC_FX8,
		SC_CLEAR_FX, SC_GAIN_UP, SC_GAIN_DN, SC_TREBLE_UP, SC_TREBLE_DN,
		SC_BASS_UP, SC_BASS_DN, SC_REC_ON, SC_REC_OFF, SC_PLAY_ON, SC_PLAY_OFF,
		SC_ESC
	};

	logic               CLOCK_50;
	logic               rst;
	logic [7:0]         scan_code;
	logic               scan_valid;
	logic signed [31:0] audio_in;
	amp_state_t         state;
	level_t             amplitude;
	logic [5:0][6:0]    hex;
	logic [9:0]         ledr;
	int                 err_count;
	int                 chk_count;

	guitar_amp_top i_guitar_amp_top (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.audio_in   (audio_in),
		.state      (state),
		.amplitude  (amplitude),
		.hex        (hex),
		.ledr       (ledr)
	);

	amp_checker i_amp_checker (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.audio_in   (audio_in),
		.state      (state),
		.amplitude  (amplitude),
		.hex        (hex),
		.ledr       (ledr),
		.err_count  (err_count),
		.chk_count  (chk_count)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: run did not complete within %0d ns", TIMEOUT_NS);
		$display("test failed");
		$finish;
	end

	// One cycle of key stimulus, just after the edge
	task automatic drive(input logic [7:0] code, input logic vld);
		@(posedge CLOCK_50);
		#1;
		scan_code = code;
		scan_valid = vld;
	endtask

	function automatic logic is_known(input logic [7:0] code);
		if (code == SC_BREAK)
			return 1'b1;
		for (int i = 0; i < 21; i++)
			if (ALL_KEYS[i] == code)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic run_levels();
		logic [31:0] r;
		int len;
		for (int i = 0; i < 6; i++) begin
			r = $urandom;
			len = 101 + int'(r % 40); // Always past full travel
			repeat (len) drive(LEVEL_KEYS[i], 1'b1);
		end
		repeat (200) begin
			r = $urandom;
			drive(LEVEL_KEYS[r[2:0] % 6], r[3]); // Mixed, with gaps
		end
	endtask

	task automatic run_effects();
		logic [31:0] r;
		repeat (400) begin
			r = $urandom;
			if (r[1:0] == 2'd0)
				drive(8'h00, 1'b0);
			else if (r[7:4] == 4'd0)
				drive(SC_CLEAR_FX, 1'b1);
			else
				drive(FX_KEYS[r[10:8]], 1'b1);
		end
	endtask

	task automatic run_rec_play();
		logic [31:0] r;
		repeat (300) begin
			r = $urandom;
			if (r[0])
				drive(RP_KEYS[r[2:1]], 1'b1);
			else
				drive(8'h00, 1'b0);
		end
	endtask

	task automatic run_break();
		logic [31:0] r;
		logic [7:0]  junk;
		repeat (150) begin
			r = $urandom;
			drive(SC_BREAK, 1'b1);
			if (r[0])
				drive(8'h00, 1'b0); // Gap between prefix and key
			drive(ALL_KEYS[r[12:8] % 21], 1'b1);
			junk = r[23:16];
			if (is_known(junk))
				junk = 8'h00; // Unmapped code
			drive(junk, 1'b1);
		end
	endtask

	task automatic run_soft_reset();
		logic [31:0] r;
		repeat (400) begin
			r = $urandom;
			if (r[5:0] == 6'd0)
				drive(SC_ESC, 1'b1);
			else if (r[6])
				drive(ALL_KEYS[r[12:8] % 21], 1'b1);
			else
				drive(8'h00, 1'b0);
		end
	endtask

	task automatic run_amplitude();
		logic [31:0]        r;
		logic signed [31:0] s;
		repeat (400) begin
			r = $urandom;
			case (r[2:0])
				3'd0:    s = 32'sd0;
				3'd1:    s = 32'sh7FFF_FFFF; // Full scale
				3'd2:    s = 32'sh8000_0000; // Most negative
				3'd3:    s = -32'sd1;
				3'd4:    s = DEF_AMP_DIVISOR - 32'sd1; // Quotient just under 1
				3'd5:    s = $urandom; // Either sign
				default: s = {1'b0, r[31:1]};
			endcase
			@(posedge CLOCK_50);
			#1;
			scan_valid = 1'b0;
			audio_in = s;
		end
	endtask

	// Let the pipeline drain, then report the phase
	task automatic finish_phase(input string name, input int errs_before);
		int n;
		repeat (4) drive(8'h00, 1'b0);
		n = err_count - errs_before;
		$display("%s: %0d mismatches, %s", name, n, (n == 0) ? "ok" : "bad");
	endtask

	initial begin
		int unsigned seed_val;
		int          mark;
		rst = 1'b1;
		scan_code = 8'h00;
		scan_valid = 1'b0;
		audio_in = 32'sd0;
		seed_val = $urandom(SEED);
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		#1;
		rst = 1'b0;
		mark = err_count;
		run_levels();
		finish_phase("level saturation", mark);
		mark = err_count;
		run_effects();
		finish_phase("effects", mark);
		mark = err_count;
		run_rec_play();
		finish_phase("record and play", mark);
		mark = err_count;
		run_break();
		finish_phase("break filtering", mark);
		mark = err_count;
		run_soft_reset();
		finish_phase("soft reset", mark);
		mark = err_count;
		run_amplitude();
		finish_phase("amplitude", mark);
		$display("Summary: %0d checks, %0d errors", chk_count, err_count);
		if (err_count == 0 && chk_count > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* build.f */
common/amp_pkg.sv
hw/key_decoder.sv
hw/amp_settings.sv
hw/level_meter.sv
hw/panel_display.sv
hw/guitar_amp_top.sv
tests/amp_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_top -f build.f -o sim_tb \
	> build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "test failed" sim.log \
	&& { echo "simulation reported a failure, see sim.log"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }
